// ==== core_pkg.sv ====
// Shared types, opcodes and pipeline structs of the core; every module imports from here
package core_pkg;

  ////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////

  // Data, address or instruction word
  typedef logic [31:0] word_t;

  // Register index, 32 entries max
  typedef logic [4:0]  rf_addr_t;

  // Raw I- and S-format immediate field
  typedef logic [11:0] imm12_t;

  // Raw U-format immediate field
  typedef logic [19:0] imm20_t;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    STORE  = 7'b0100011
  } opcode_e;

  // ALU functions, pass-through of operand b serves LUI
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_PASS_B
  } alu_op_e;

  // ADDI x0, x0, 0
  localparam word_t RESET_NOP = 32'h0000_0013;

  ////////////////////////////////////////////////////////////
  // Pipeline structs
  ////////////////////////////////////////////////////////////

  // Fetch to execute
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } if_id_pipe_t;

  // Execute to store unit
  typedef struct packed {
    word_t addr;
    word_t wdata;
  } store_req_t;

  // Decoder result inside execute
  typedef struct packed {
    rf_addr_t rs1;
    rf_addr_t rs2;
    rf_addr_t rd;
    word_t    imm;
    alu_op_e  alu_op;
    logic     use_imm;
    logic     rf_we;
    logic     is_store;
  } decode_t;

endpackage

// ==== core_fetch.sv ====
// Fetch stage: owns the PC, drives the instruction bus and buffers one instruction for execute
`timescale 1ns/1ps

module core_fetch (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Static configuration and enable
  input  core_pkg::word_t       boot_addr_i,
  input  logic                  fetch_enable_i,

  // Instruction bus
  output logic                  instr_req_o,
  output core_pkg::word_t       instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  core_pkg::word_t       instr_rdata_i,

  // Handshake with execute
  input  logic                  ex_ready_i,
  output core_pkg::if_id_pipe_t if_id_pipe_o
);
  import core_pkg::*;

  word_t       pc_q;
  word_t       fetch_pc_q;
  logic        boot_done_q;
  logic        outstanding_q;
  logic        req_hold_q;
  logic        buf_free;
  logic        consume;
  if_id_pipe_t buf_q;

  // Buffer empty now or emptied by execute this cycle
  assign buf_free = !buf_q.valid || ex_ready_i;
  assign consume  = buf_q.valid && ex_ready_i;

  // A request once raised stays up until granted
  assign instr_req_o  = req_hold_q ||
                        (boot_done_q && fetch_enable_i && !outstanding_q && buf_free);
  assign instr_addr_o = pc_q;
  assign if_id_pipe_o = buf_q;

  ////////////////////////////////////////////////////////////
  // PC and bus control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q          <= '0;
      boot_done_q   <= 1'b0;
      outstanding_q <= 1'b0;
      req_hold_q    <= 1'b0;
    end else begin
      // First cycle out of reset picks up the boot address
      if (!boot_done_q) begin
        pc_q        <= boot_addr_i;
        boot_done_q <= 1'b1;
      end else if (instr_req_o && instr_gnt_i) begin
        pc_q <= pc_q + 32'd4;
      end
      req_hold_q <= instr_req_o && !instr_gnt_i;
      // One fetch in flight between gnt and rvalid
      if (instr_req_o && instr_gnt_i) begin
        outstanding_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  // Address of the fetch in flight, tags the response
  always_ff @(posedge clk_i) begin
    if (instr_req_o && instr_gnt_i) begin
      fetch_pc_q <= pc_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Instruction buffer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      buf_q <= '{valid: 1'b0, pc: '0, instr: RESET_NOP};
    end else if (instr_rvalid_i) begin
      // Buffer is always empty when a response lands
      buf_q <= '{valid: 1'b1, pc: fetch_pc_q, instr: instr_rdata_i};
    end else if (consume) begin
      buf_q.valid <= 1'b0;
    end
  end

endmodule

// ==== core_decoder.sv ====
// Combinational decoder for the supported RV32I subset as used inside the execute stage
`timescale 1ns/1ps

module core_decoder (
  input  core_pkg::word_t   instr_i,
  output core_pkg::decode_t dec_o
);
  import core_pkg::*;

  // funct fields of the supported instructions
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SW  = 3'b010;
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm12_t     imm_i;
  imm12_t     imm_s;
  imm20_t     imm_u;

  // Field extraction
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign imm_i  = instr_i[31:20];
  assign imm_s  = {instr_i[31:25], instr_i[11:7]};
  assign imm_u  = instr_i[31:12];

  always_comb begin
    // No-op unless matched below
    dec_o          = '0;
    dec_o.rs1      = instr_i[19:15];
    dec_o.rs2      = instr_i[24:20];
    dec_o.rd       = instr_i[11:7];
    dec_o.alu_op   = ALU_ADD;

    case (opcode)
      OP_IMM: begin
        // ADDI only
        if (funct3 == F3_ADD) begin
          dec_o.imm     = {{20{imm_i[11]}}, imm_i};
          dec_o.use_imm = 1'b1;
          dec_o.rf_we   = 1'b1;
        end
      end
      OP: begin
        if (funct3 == F3_ADD && funct7 == F7_ADD) begin
          dec_o.rf_we  = 1'b1;
        end else if (funct3 == F3_ADD && funct7 == F7_SUB) begin
          dec_o.alu_op = ALU_SUB;
          dec_o.rf_we  = 1'b1;
        end
      end
      LUI: begin
        // Upper immediate goes straight through the ALU
        dec_o.imm     = {imm_u, 12'h000};
        dec_o.alu_op  = ALU_PASS_B;
        dec_o.use_imm = 1'b1;
        dec_o.rf_we   = 1'b1;
      end
      STORE: begin
        // SW only with address rs1 + S-immediate
        if (funct3 == F3_SW) begin
          dec_o.imm      = {{20{imm_s[11]}}, imm_s};
          dec_o.use_imm  = 1'b1;
          dec_o.is_store = 1'b1;
        end
      end
      default: begin
        // Anything else stays a no-op
      end
    endcase
  end

endmodule

// ==== core_register_file.sv ====
// Register file with two combinational read ports, one write port and x0 fixed to zero
`timescale 1ns/1ps

module core_register_file #(
  parameter int NUM_REGS = 32
) (
  input  logic               clk_i,
  input  logic               rst_n_i,

  // Read ports
  input  core_pkg::rf_addr_t raddr_a_i,
  output core_pkg::word_t    rdata_a_o,
  input  core_pkg::rf_addr_t raddr_b_i,
  output core_pkg::word_t    rdata_b_o,

  // Write port
  input  core_pkg::rf_addr_t waddr_i,
  input  core_pkg::word_t    wdata_i,
  input  logic               we_i
);
  import core_pkg::*;

  localparam int AW = $clog2(NUM_REGS);

  word_t regs_q [NUM_REGS];

  // x0 and indices past the file read as zero
  assign rdata_a_o = (raddr_a_i == '0 || raddr_a_i >= NUM_REGS) ? '0 : regs_q[raddr_a_i[AW-1:0]];
  assign rdata_b_o = (raddr_b_i == '0 || raddr_b_i >= NUM_REGS) ? '0 : regs_q[raddr_b_i[AW-1:0]];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      // Entry 0 is never written
      for (int i = 1; i < NUM_REGS; i++) begin
        if (we_i && waddr_i == rf_addr_t'(i)) begin
          regs_q[i] <= wdata_i;
        end
      end
    end
  end

endmodule

// ==== core_ex_stage.sv ====
// Execute stage: decodes, reads operands, runs the ALU, writes back and issues stores
`timescale 1ns/1ps

module core_ex_stage #(
  parameter int NUM_REGS = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // From fetch
  input  core_pkg::if_id_pipe_t if_id_pipe_i,
  output logic                  ex_ready_o,

  // To store unit
  input  logic                  store_busy_i,
  output logic                  store_valid_o,
  output core_pkg::store_req_t  store_req_o
);
  import core_pkg::*;

  decode_t dec;
  word_t   rs1_data;
  word_t   rs2_data;
  word_t   op_b;
  word_t   alu_result;
  logic    is_store;
  logic    consume;

  ////////////////////////////////////////////////////////////
  // Decode and operand read
  ////////////////////////////////////////////////////////////

  core_decoder decoder_i (
    .instr_i ( if_id_pipe_i.instr ),
    .dec_o   ( dec                )
  );

  core_register_file #(
    .NUM_REGS ( NUM_REGS )
  ) register_file_i (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .raddr_a_i ( dec.rs1    ),
    .rdata_a_o ( rs1_data   ),
    .raddr_b_i ( dec.rs2    ),
    .rdata_b_o ( rs2_data   ),
    .waddr_i   ( dec.rd     ),
    .wdata_i   ( alu_result ),
    // Write lands on the edge that consumes the instruction
    .we_i      ( consume && dec.rf_we )
  );

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  assign op_b = dec.use_imm ? dec.imm : rs2_data;

  always_comb begin
    case (dec.alu_op)
      ALU_SUB:    alu_result = rs1_data - op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = rs1_data + op_b;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////

  assign is_store = if_id_pipe_i.valid && dec.is_store;

  // Only a store meeting a busy store unit stalls
  assign ex_ready_o = !(is_store && store_busy_i);
  assign consume    = if_id_pipe_i.valid && ex_ready_o;

  // One-cycle pulse, the instruction leaves in the same cycle
  assign store_valid_o     = is_store && !store_busy_i;
  assign store_req_o.addr  = alu_result;
  assign store_req_o.wdata = rs2_data;

endmodule

// ==== core_store_unit.sv ====
// Store unit: registers one store from execute and runs it over the data bus
`timescale 1ns/1ps

module core_store_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // From execute
  input  logic                 store_valid_i,
  input  core_pkg::store_req_t store_req_i,
  output logic                 store_busy_o,

  // Data bus
  output logic                 data_req_o,
  output core_pkg::word_t      data_addr_o,
  output core_pkg::word_t      data_wdata_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_RESP
  } state_e;

  state_e     state_q;
  store_req_t req_q;

  // FSM: idle, request until gnt, wait for the response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:      if (store_valid_i) state_q <= REQ;
        REQ:       if (data_gnt_i) state_q <= WAIT_RESP;
        WAIT_RESP: if (data_rvalid_i) state_q <= IDLE;
        default:   state_q <= IDLE;
      endcase
    end
  end

  // Address and data held stable while req is up
  always_ff @(posedge clk_i) begin
    if (store_valid_i && state_q == IDLE) begin
      req_q <= store_req_i;
    end
  end

  // Busy from the cycle after the pulse until the response retires
  assign store_busy_o = (state_q != IDLE);

  assign data_req_o   = (state_q == REQ);
  assign data_addr_o  = req_q.addr;
  assign data_wdata_o = req_q.wdata;

endmodule

// ==== core_top.sv ====
// Core top level: connects fetch, execute and store unit to the instruction and data buses
`timescale 1ns/1ps

module core_top #(
  parameter int NUM_REGS = 32
) (
  // Clock and reset
  input  logic            clk_i,
  input  logic            rst_n_i,

  // Boot address and fetch control
  input  core_pkg::word_t boot_addr_i,
  input  logic            fetch_enable_i,

  // Instruction bus
  output logic            instr_req_o,
  output core_pkg::word_t instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  core_pkg::word_t instr_rdata_i,

  // Data bus, full-word stores only
  output logic            data_req_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i
);
  import core_pkg::*;

  // Fetch to execute
  if_id_pipe_t if_id_pipe;
  logic        ex_ready;

  // Execute to store unit
  store_req_t  store_req;
  logic        store_valid;
  logic        store_busy;

  ////////////////////////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////////////////////////

  core_fetch fetch_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .ex_ready_i     ( ex_ready       ),
    .if_id_pipe_o   ( if_id_pipe     )
  );

  ////////////////////////////////////////////////////////////
  // Execute, with decoder and register file
  ////////////////////////////////////////////////////////////

  core_ex_stage #(
    .NUM_REGS ( NUM_REGS )
  ) ex_stage_i (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .if_id_pipe_i  ( if_id_pipe  ),
    .ex_ready_o    ( ex_ready    ),
    .store_busy_i  ( store_busy  ),
    .store_valid_o ( store_valid ),
    .store_req_o   ( store_req   )
  );

  ////////////////////////////////////////////////////////////
  // Store unit
  ////////////////////////////////////////////////////////////

  core_store_unit store_unit_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .store_valid_i ( store_valid   ),
    .store_req_i   ( store_req     ),
    .store_busy_o  ( store_busy    ),
    .data_req_o    ( data_req_o    ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i )
  );

endmodule

// ==== tb_core.sv ====
// Directed simulation top that runs core_top through test tasks against a memory model and bus responders
`timescale 1ns/1ps

module tb_core;
  import core_pkg::*;

  localparam int    NUM_REGS       = 32;
  localparam int    TIMEOUT_CYCLES = 2000;
  // ADDI x0, x0, 0 from the ISA encoding
  localparam word_t NOP_WORD       = 32'h0000_0013;

  logic       clk = 1'b0;
  logic       rst_n;
  word_t      boot_addr;
  logic       fetch_enable;
  logic       instr_req;
  word_t      instr_addr;
  logic       instr_gnt;
  logic       instr_rvalid;
  word_t      instr_rdata;
  logic       data_req;
  word_t      data_addr;
  word_t      data_wdata;
  logic       data_gnt;
  logic       data_rvalid;

  // Program image and logged data bus transfers
  word_t      prog [$];
  store_req_t store_log [$];
  store_req_t entry;

  // Responder state
  int         seed = 49143;
  logic       instr_pending;
  int         instr_delay;
  int         instr_idx;
  int         last_fetch_idx;
  logic       data_pending;
  int         data_delay;

  always #5 clk = ~clk;

  core_top #(
    .NUM_REGS ( NUM_REGS )
  ) uut (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .boot_addr_i    ( boot_addr    ),
    .fetch_enable_i ( fetch_enable ),
    .instr_req_o    ( instr_req    ),
    .instr_addr_o   ( instr_addr   ),
    .instr_gnt_i    ( instr_gnt    ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_rdata_i  ( instr_rdata  ),
    .data_req_o     ( data_req     ),
    .data_addr_o    ( data_addr    ),
    .data_wdata_o   ( data_wdata   ),
    .data_gnt_i     ( data_gnt     ),
    .data_rvalid_i  ( data_rvalid  )
  );

  ////////////////////////////////////////////////////////////
  // Instruction encoders for the RV32I formats
  ////////////////////////////////////////////////////////////

  function automatic word_t enc_addi(input rf_addr_t rd, input rf_addr_t rs1, input imm12_t imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic word_t enc_add(input rf_addr_t rd, input rf_addr_t rs1, input rf_addr_t rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic word_t enc_sub(input rf_addr_t rd, input rf_addr_t rs1, input rf_addr_t rs2);
    return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic word_t enc_lui(input rf_addr_t rd, input imm20_t imm);
    return {imm, rd, 7'b0110111};
  endfunction

  // SW rs2, imm(rs1)
  function automatic word_t enc_sw(input rf_addr_t rs2, input rf_addr_t rs1, input imm12_t imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // Memory model that returns NOPs past the end of the program
  function automatic word_t fetch_word(input int idx);
    if (idx >= 0 && idx < prog.size()) begin
      return prog[idx];
    end
    return NOP_WORD;
  endfunction

  function automatic int gnt_delay();
    return int'($unsigned($random(seed)) % 32'd4);
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////
  // Bus responders driven on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic respond_instr();
    if (instr_gnt) begin
      // Answer the transfer of the last rising edge
      instr_gnt    = 1'b0;
      instr_rvalid = 1'b1;
      instr_rdata  = fetch_word(instr_idx);
    end else begin
      instr_rvalid = 1'b0;
      if (instr_req) begin
        if (!instr_pending) begin
          instr_pending = 1'b1;
          instr_delay   = gnt_delay();
        end
        if (instr_delay == 0) begin
          instr_gnt      = 1'b1;
          instr_pending  = 1'b0;
          instr_idx      = int'((instr_addr - boot_addr) >> 2);
          last_fetch_idx <= instr_idx;
        end else begin
          instr_delay = instr_delay - 1;
        end
      end
    end
  endtask

  task automatic respond_data();
    if (data_gnt) begin
      data_gnt    = 1'b0;
      data_rvalid = 1'b1;
    end else begin
      data_rvalid = 1'b0;
      if (data_req) begin
        if (!data_pending) begin
          data_pending = 1'b1;
          data_delay   = gnt_delay();
        end
        if (data_delay == 0) begin
          data_gnt     = 1'b1;
          data_pending = 1'b0;
          // Monitor logs address and data that hold until the granting edge
          entry.addr   = data_addr;
          entry.wdata  = data_wdata;
          store_log.push_back(entry);
        end else begin
          data_delay = data_delay - 1;
        end
      end
    end
  endtask

  // One process for both buses keeps the random sequence fixed
  always @(negedge clk) begin
    if (!rst_n) begin
      instr_gnt      = 1'b0;
      instr_rvalid   = 1'b0;
      instr_pending  = 1'b0;
      last_fetch_idx <= -1;
      data_gnt       = 1'b0;
      data_rvalid    = 1'b0;
      data_pending   = 1'b0;
      store_log.delete();
    end else begin
      respond_instr();
      respond_data();
    end
  end

  ////////////////////////////////////////////////////////////
  // Test helpers
  ////////////////////////////////////////////////////////////

  // Asserts reset for 5 cycles up to the release by the caller
  // Program is loaded while reset is held
  task automatic reset_core(input word_t boot);
    @(negedge clk);
    rst_n        <= 1'b0;
    fetch_enable <= 1'b0;
    boot_addr    <= boot;
    prog.delete();
    repeat (4) begin
      @(negedge clk);
      assert (!instr_req && !data_req) else
        fail_now("Bus request raised while reset is asserted");
    end
  endtask

  task automatic run_program(input string name, input int n_stores);
    int cycles;
    cycles = 0;
    @(negedge clk);
    rst_n        <= 1'b1;
    fetch_enable <= 1'b1;
    // Two words past the end means every program instruction retired
    while (!(last_fetch_idx > prog.size() + 1 && !data_req)) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        fail_now($sformatf("%s: program did not finish before the timeout", name));
      end
    end
    assert (store_log.size() == n_stores) else
      fail_now($sformatf("MISMATCH %s store count expected %0d actual %0d",
                         name, n_stores, store_log.size()));
  endtask

  task automatic check_store(input string name, input int idx, input word_t exp_addr,
                             input word_t exp_data);
    assert (store_log[idx].addr == exp_addr) else
      fail_now($sformatf("MISMATCH %s store %0d addr expected %h actual %h",
                         name, idx, exp_addr, store_log[idx].addr));
    assert (store_log[idx].wdata == exp_data) else
      fail_now($sformatf("MISMATCH %s store %0d data expected %h actual %h",
                         name, idx, exp_data, store_log[idx].wdata));
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_and_boot();
    int cycles;
    reset_core(32'h0000_2000);
    @(negedge clk);
    rst_n <= 1'b1;
    // Out of reset but not enabled
    repeat (10) begin
      @(negedge clk);
      assert (!instr_req && !data_req) else
        fail_now("Bus request raised while fetch is disabled");
    end
    fetch_enable <= 1'b1;
    cycles = 0;
    while (!instr_req) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        fail_now("reset_and_boot: no instruction request after fetch enable");
      end
    end
    assert (instr_addr == 32'h0000_2000) else
      fail_now($sformatf("MISMATCH reset_and_boot first fetch expected %h actual %h",
                         32'h0000_2000, instr_addr));
  endtask

  task automatic test_arith_chains();
    word_t r1;
    word_t r2;
    word_t r5;
    word_t r8;
    reset_core(32'h0000_1000);
    prog.push_back(enc_addi(5'd1, 5'd0, imm12_t'(100)));
    prog.push_back(enc_addi(5'd2, 5'd0, imm12_t'(-7)));
    prog.push_back(enc_add(5'd3, 5'd1, 5'd2));
    prog.push_back(enc_sub(5'd4, 5'd2, 5'd1));
    // All ones then wrap to zero
    prog.push_back(enc_addi(5'd5, 5'd0, imm12_t'(-1)));
    prog.push_back(enc_addi(5'd6, 5'd5, imm12_t'(1)));
    prog.push_back(enc_add(5'd7, 5'd5, 5'd5));
    prog.push_back(enc_sub(5'd8, 5'd0, 5'd1));
    prog.push_back(enc_addi(5'd9, 5'd8, imm12_t'(-2048)));
    prog.push_back(enc_sw(5'd3, 5'd0, imm12_t'(0)));
    prog.push_back(enc_sw(5'd4, 5'd0, imm12_t'(4)));
    prog.push_back(enc_sw(5'd6, 5'd0, imm12_t'(8)));
    prog.push_back(enc_sw(5'd7, 5'd0, imm12_t'(12)));
    prog.push_back(enc_sw(5'd9, 5'd0, imm12_t'(16)));
    run_program("arith_chains", 5);
    r1 = 32'd100;
    r2 = word_t'(-7);
    r5 = word_t'(-1);
    r8 = 32'd0 - r1;
    check_store("arith_chains", 0, 32'd0, r1 + r2);
    check_store("arith_chains", 1, 32'd4, r2 - r1);
    check_store("arith_chains", 2, 32'd8, r5 + 32'd1);
    check_store("arith_chains", 3, 32'd12, r5 + r5);
    check_store("arith_chains", 4, 32'd16, r8 + word_t'(-2048));
  endtask

  task automatic test_lui_and_store();
    word_t base;
    reset_core(32'h0000_4000);
    prog.push_back(enc_lui(5'd1, 20'h12345));
    prog.push_back(enc_addi(5'd1, 5'd1, 12'h678));
    // Negative low part borrows from the upper half
    prog.push_back(enc_lui(5'd2, 20'hDEADC));
    prog.push_back(enc_addi(5'd2, 5'd2, imm12_t'(-273)));
    prog.push_back(enc_lui(5'd3, 20'h80000));
    prog.push_back(enc_sw(5'd1, 5'd3, imm12_t'(16)));
    prog.push_back(enc_sw(5'd2, 5'd3, imm12_t'(-4)));
    run_program("lui_and_store", 2);
    base = 32'h80000 << 12;
    check_store("lui_and_store", 0, base + 32'd16, (32'h12345 << 12) + 32'h678);
    check_store("lui_and_store", 1, base + word_t'(-4), (32'hDEADC << 12) + word_t'(-273));
  endtask

  task automatic test_zero_reg_and_illegal();
    reset_core(32'h0000_0800);
    prog.push_back(enc_addi(5'd0, 5'd0, imm12_t'(55)));
    prog.push_back(enc_sw(5'd0, 5'd0, imm12_t'(64)));
    prog.push_back(enc_addi(5'd7, 5'd0, imm12_t'(123)));
    // AND x7, x0, x0 and LW x7, 0(x0)
    prog.push_back({7'b0000000, 5'd0, 5'd0, 3'b111, 5'd7, 7'b0110011});
    prog.push_back({12'd0, 5'd0, 3'b010, 5'd7, 7'b0000011});
    // SB x7, 72(x0) is a byte store outside the subset
    prog.push_back({7'd2, 5'd7, 5'd0, 3'b000, 5'd8, 7'b0100011});
    prog.push_back(32'hFFFF_FFFF);
    prog.push_back(enc_sw(5'd7, 5'd0, imm12_t'(68)));
    run_program("zero_reg_and_illegal", 2);
    check_store("zero_reg_and_illegal", 0, 32'd64, 32'd0);
    check_store("zero_reg_and_illegal", 1, 32'd68, 32'd123);
  endtask

  task automatic test_random_backpressure();
    store_req_t expected [$];
    store_req_t exp_entry;
    word_t      r1;
    word_t      r2;
    word_t      base;
    int         imm;
    reset_core(32'h0001_0000);
    base = 32'h0000_2000;
    r1   = 32'd5;
    r2   = 32'd1000;
    prog.push_back(enc_lui(5'd10, 20'h00002));
    prog.push_back(enc_addi(5'd1, 5'd0, imm12_t'(5)));
    prog.push_back(enc_addi(5'd2, 5'd0, imm12_t'(1000)));
    // Back-to-back stores stall execute on the busy store unit
    for (int k = 0; k < 8; k++) begin
      imm = k * 37 - 100;
      prog.push_back(enc_addi(5'd1, 5'd1, imm12_t'(imm)));
      prog.push_back(enc_sub(5'd2, 5'd2, 5'd1));
      prog.push_back(enc_add(5'd3, 5'd1, 5'd2));
      prog.push_back(enc_sw(5'd1, 5'd10, imm12_t'(k * 8)));
      prog.push_back(enc_sw(5'd3, 5'd10, imm12_t'(k * 8 + 4)));
      r1 = r1 + word_t'(imm);
      r2 = r2 - r1;
      exp_entry.addr  = base + word_t'(k * 8);
      exp_entry.wdata = r1;
      expected.push_back(exp_entry);
      exp_entry.addr  = base + word_t'(k * 8 + 4);
      exp_entry.wdata = r1 + r2;
      expected.push_back(exp_entry);
    end
    run_program("random_backpressure", expected.size());
    foreach (expected[i]) begin
      check_store("random_backpressure", i, expected[i].addr, expected[i].wdata);
    end
  endtask

  initial begin
    rst_n        <= 1'b0;
    fetch_enable <= 1'b0;
    boot_addr    <= '0;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    data_gnt     = 1'b0;
    data_rvalid  = 1'b0;
    test_reset_and_boot();
    test_arith_chains();
    test_lui_and_store();
    test_zero_reg_and_illegal();
    test_random_backpressure();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== all.f ====
core_pkg.sv
core_fetch.sv
core_decoder.sv
core_register_file.sv
core_ex_stage.sv
core_store_unit.sv
core_top.sv
tb_core.sv

// ==== Makefile ====
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(wildcard *.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
